// ==== rv32i_types_pkg.sv ====
// shared front-end types; all addresses are byte addresses and bus endianness is fixed at build time
package rv32i_types_pkg;

  // one machine word on every path of the front end
  typedef logic [31:0] word_t;

  // pc loaded by reset and the pc inserted when a fetch is misaligned
  localparam word_t RESET_PC    = 32'h200;
  localparam word_t TRAP_VECTOR = 32'h100;

  // with "little" every word on the instruction bus arrives byte-swapped
  localparam string BUS_ENDIANNESS = "little";

  // direct-mapped btb geometry, the index sits just above the byte offset
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;

  // instruction bus request and response, both plain levels
  typedef struct packed {
    word_t addr;
    logic  ren;
  } ibus_req_t;

  typedef struct packed {
    word_t rdata;
    logic  busy;
  } ibus_rsp_t;

  // fetch/execute register where token marks a valid instruction
  typedef struct packed {
    logic  token;
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  prediction;
  } fetch_ex_reg_t;

  // branch or jump resolution reported by execute
  typedef struct packed {
    logic  valid;
    word_t pc;
    logic  taken;
    word_t target;
    logic  mispredict;
    word_t brj_addr;
  } ex_resolve_t;

  // btb answer for the pc currently in fetch
  typedef struct packed {
    logic  predict_taken;
    word_t target_addr;
  } prediction_t;

  // pipeline controls from the hazard unit
  typedef struct packed {
    logic pc_en;
    logic npc_sel;
    logic insert_priv_pc;
    logic if_ex_stall;
    logic if_ex_flush;
    logic iren;
  } hazard_ctrl_t;

  // fetch-side status seen by the hazard unit
  typedef struct packed {
    logic  i_mem_busy;
    logic  mal_insn;
    word_t badaddr_f;
    word_t epc_f;
  } fetch_status_t;

  // trap report, valid pulses for one cycle
  typedef struct packed {
    logic  valid;
    word_t epc;
    word_t badaddr;
  } trap_t;

endpackage

// ==== tspp_fetch_stage.sv ====
// fetch stage for a combinational instruction bus; busy low ends a fetch and no bus writes are issued
`timescale 1ns/1ps

module tspp_fetch_stage (
  input  logic                           CLK,
  input  logic                           nRST,
  input  rv32i_types_pkg::hazard_ctrl_t  ctrl,
  input  rv32i_types_pkg::prediction_t   predict,
  input  rv32i_types_pkg::ex_resolve_t   resolve,
  input  rv32i_types_pkg::ibus_rsp_t     ibus_rsp,
  output rv32i_types_pkg::ibus_req_t     ibus_req,
  output rv32i_types_pkg::word_t         current_pc,
  output rv32i_types_pkg::fetch_status_t status,
  output rv32i_types_pkg::fetch_ex_reg_t fetch_ex_reg
);
  import rv32i_types_pkg::*;

  // pc of the instruction being fetched and the candidates for the next one
  word_t pc;
  word_t pc4;
  word_t npc;

  // instruction word after the endian rule has been applied
  word_t instr;

  // the pc only moves when the hazard unit allows it
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (ctrl.pc_en) begin
      pc <= npc;
    end
  end

  assign pc4 = pc + 32'd4;

  // the btb looks up the same pc in parallel with the bus access
  assign current_pc = pc;

  // next pc priority is trap vector, then the execute redirect
  // then the btb target and finally the sequential address
  always_comb begin
    if (ctrl.insert_priv_pc) begin
      npc = TRAP_VECTOR;
    end else if (ctrl.npc_sel) begin
      npc = resolve.brj_addr;
    end else if (predict.predict_taken) begin
      npc = predict.target_addr;
    end else begin
      npc = pc4;
    end
  end

  // the address always follows the pc and the read level comes from hazard control
  assign ibus_req.addr = pc;
  assign ibus_req.ren  = ctrl.iren;

  // a little-endian bus delivers each word with its bytes reversed
  always_comb begin
    if (BUS_ENDIANNESS == "little") begin
      instr = {ibus_rsp.rdata[7:0], ibus_rsp.rdata[15:8],
               ibus_rsp.rdata[23:16], ibus_rsp.rdata[31:24]};
    end else begin
      instr = ibus_rsp.rdata;
    end
  end

  // a flush turns the slot into a bubble, a stall keeps what execute holds
  // and otherwise the word fetched this cycle moves on to execute
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fetch_ex_reg <= '0;
    end else if (ctrl.if_ex_flush) begin
      fetch_ex_reg <= '0;
    end else if (!ctrl.if_ex_stall) begin
      fetch_ex_reg.token      <= 1'b1;
      fetch_ex_reg.pc         <= pc;
      fetch_ex_reg.pc4        <= pc4;
      fetch_ex_reg.instr      <= instr;
      fetch_ex_reg.prediction <= predict.predict_taken;
    end
  end

  // busy is passed straight through so the hazard unit can hold the pc
  assign status.i_mem_busy = ibus_rsp.busy;

  // any pc that is not word aligned is reported as a misaligned fetch
  assign status.mal_insn = (pc[1:0] != 2'b00);

  // the faulting address and the exception pc are both the fetch pc here
  assign status.badaddr_f = pc;
  assign status.epc_f     = pc;

  // the hazard unit must never ask to hold and drop the same slot at once
  a_flush_stall_exclusive: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(ctrl.if_ex_flush && ctrl.if_ex_stall)
  );

endmodule

// ==== branch_target_buffer.sv ====
// direct-mapped btb with 2-bit counters; lookup is combinational and a resolve updates it on the next edge
`timescale 1ns/1ps

module branch_target_buffer (
  input  logic                          CLK,
  input  logic                          nRST,
  input  rv32i_types_pkg::word_t        current_pc,
  input  rv32i_types_pkg::ex_resolve_t  resolve,
  output rv32i_types_pkg::prediction_t  predict
);
  import rv32i_types_pkg::*;

  // payload of one entry, the valid bit lives apart so that reset can clear it
  typedef struct packed {
    logic [BTB_TAG_W-1:0] tag;
    word_t                target;
    logic [1:0]           counter;
  } btb_entry_t;

  logic [BTB_ENTRIES-1:0] entry_valid;
  btb_entry_t             entries [BTB_ENTRIES];

  // read side, driven by the pc in fetch
  logic [BTB_IDX_W-1:0] rd_idx;
  logic [BTB_TAG_W-1:0] rd_tag;
  btb_entry_t           rd_entry;
  logic                 rd_hit;

  // update side, driven by the branch that execute resolves
  logic [BTB_IDX_W-1:0] up_idx;
  logic [BTB_TAG_W-1:0] up_tag;
  btb_entry_t           up_entry;
  btb_entry_t           up_next;
  logic                 up_hit;
  logic                 up_taken;
  logic                 up_install;
  logic                 up_write;

  assign rd_idx   = current_pc[BTB_IDX_W+1:2];
  assign rd_tag   = current_pc[31:BTB_IDX_W+2];
  assign rd_entry = entries[rd_idx];
  assign rd_hit   = entry_valid[rd_idx] && (rd_entry.tag == rd_tag);

  // predict taken only on a hit whose counter sits in a taken state
  assign predict.predict_taken = rd_hit && rd_entry.counter[1];
  assign predict.target_addr   = rd_entry.target;

  assign up_idx   = resolve.pc[BTB_IDX_W+1:2];
  assign up_tag   = resolve.pc[31:BTB_IDX_W+2];
  assign up_entry = entries[up_idx];
  assign up_hit   = entry_valid[up_idx] && (up_entry.tag == up_tag);

  // a taken jump to a misaligned target traps anyway and is kept out of the table
  assign up_taken = resolve.taken && (resolve.target[1:0] == 2'b00);

  // a taken miss claims the slot even if another branch held it
  assign up_install = resolve.valid && up_taken && !up_hit;

  always_comb begin
    up_next  = up_entry;
    up_write = 1'b0;
    if (resolve.valid) begin
      if (up_install) begin
        // new entries start weakly taken
        up_next.tag     = up_tag;
        up_next.target  = resolve.target;
        up_next.counter = 2'd2;
        up_write        = 1'b1;
      end else if (up_taken) begin
        // a taken hit strengthens the counter and refreshes the target
        up_next.target = resolve.target;
        if (up_entry.counter != 2'd3) begin
          up_next.counter = up_entry.counter + 2'd1;
        end
        up_write = 1'b1;
      end else if (!resolve.taken && up_hit) begin
        // a not-taken hit weakens the counter down to zero
        if (up_entry.counter != 2'd0) begin
          up_next.counter = up_entry.counter - 2'd1;
        end
        up_write = 1'b1;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      entry_valid <= '0;
    end else if (up_install) begin
      entry_valid[up_idx] <= 1'b1;
    end
  end

  // the table itself is plain storage, entries count only once valid is set
  always_ff @(posedge CLK) begin
    if (up_write) begin
      entries[up_idx] <= up_next;
    end
  end

  // whatever execute resolves, fetch is never steered to a misaligned target
  a_hit_target_aligned: assert property (
    @(posedge CLK) disable iff (!nRST)
    rd_hit |-> (rd_entry.target[1:0] == 2'b00)
  );

endmodule

// ==== tspp_hazard_unit.sv ====
// hazard control for the two-stage front end; only the trap report is registered
`timescale 1ns/1ps

module tspp_hazard_unit (
  input  logic                           CLK,
  input  logic                           nRST,
  input  rv32i_types_pkg::fetch_status_t status,
  input  rv32i_types_pkg::ex_resolve_t   resolve,
  input  logic                           ex_stall,
  output rv32i_types_pkg::hazard_ctrl_t  ctrl,
  output rv32i_types_pkg::trap_t         trap
);
  import rv32i_types_pkg::*;

  logic  mispredict;
  logic  redirect;
  logic  trap_valid;
  word_t trap_epc;
  word_t trap_badaddr;

  // execute only redirects when a resolved branch went the wrong way
  assign mispredict = resolve.valid && resolve.mispredict;

  // either kind of redirect moves the pc regardless of the bus
  assign redirect = mispredict || status.mal_insn;

  // the rules are checked from the highest priority downwards
  always_comb begin
    ctrl      = '0;
    ctrl.iren = 1'b1;
    if (mispredict) begin
      // the wrong-path instruction in fetch is dropped
      ctrl.npc_sel     = 1'b1;
      ctrl.pc_en       = 1'b1;
      ctrl.if_ex_flush = 1'b1;
    end else if (status.mal_insn) begin
      // a misaligned pc goes to the trap vector
      ctrl.insert_priv_pc = 1'b1;
      ctrl.pc_en          = 1'b1;
      ctrl.if_ex_flush    = 1'b1;
    end else if (ex_stall) begin
      // execute is full so both stages hold and the bus goes idle
      ctrl.if_ex_stall = 1'b1;
      ctrl.iren        = 1'b0;
    end else if (status.i_mem_busy) begin
      // the fetch is still waiting and execute receives a bubble
      ctrl.if_ex_flush = 1'b1;
    end else begin
      ctrl.pc_en = 1'b1;
    end
  end

  // the pulse lines up with the edge on which the pc takes the trap vector
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      trap_valid <= 1'b0;
    end else begin
      trap_valid <= ctrl.insert_priv_pc;
    end
  end

  // trap details are captured only when the trap is taken
  always_ff @(posedge CLK) begin
    if (ctrl.insert_priv_pc) begin
      trap_epc     <= status.epc_f;
      trap_badaddr <= status.badaddr_f;
    end
  end

  assign trap.valid   = trap_valid;
  assign trap.epc     = trap_epc;
  assign trap.badaddr = trap_badaddr;

  // a fetch still in flight must not let the pc run ahead
  a_busy_holds_pc: assert property (
    @(posedge CLK) disable iff (!nRST)
    (status.i_mem_busy && !redirect) |-> !ctrl.pc_en
  );

endmodule

// ==== tspp_front_end.sv ====
// front end top; execute and instruction memory are outside and must follow the combinational bus rules
`timescale 1ns/1ps

module tspp_front_end (
  input  logic                           CLK,
  input  logic                           nRST,
  input  rv32i_types_pkg::ibus_rsp_t     ibus_rsp,
  input  rv32i_types_pkg::ex_resolve_t   resolve,
  input  logic                           ex_stall,
  output rv32i_types_pkg::ibus_req_t     ibus_req,
  output rv32i_types_pkg::fetch_ex_reg_t fetch_ex_reg,
  output rv32i_types_pkg::trap_t         trap
);
  import rv32i_types_pkg::*;

  // controls from the hazard unit back into fetch
  hazard_ctrl_t  ctrl;

  // btb answer for the pc now in fetch
  prediction_t   predict;

  // pc shared between fetch and the btb lookup
  word_t         current_pc;

  // fetch-side status for the hazard unit
  fetch_status_t status;

  tspp_fetch_stage fetch_stage_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .ctrl         (ctrl),
    .predict      (predict),
    .resolve      (resolve),
    .ibus_rsp     (ibus_rsp),
    .ibus_req     (ibus_req),
    .current_pc   (current_pc),
    .status       (status),
    .fetch_ex_reg (fetch_ex_reg)
  );

  // the btb predicts on the fetch pc and learns from execute resolves
  branch_target_buffer btb_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .current_pc (current_pc),
    .resolve    (resolve),
    .predict    (predict)
  );

  tspp_hazard_unit hazard_unit_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .status   (status),
    .resolve  (resolve),
    .ex_stall (ex_stall),
    .ctrl     (ctrl),
    .trap     (trap)
  );

endmodule

// ==== tb_tspp_front_end.sv ====
// testbench playing execute and a combinational memory; every check samples on the falling edge
`timescale 1ns/1ps

module tb_tspp_front_end;
  import rv32i_types_pkg::*;

  // every instruction word is its own address with this key folded in
  localparam word_t INSTR_KEY = 32'hA5A5_0000;
  // branch pc for plain redirects, its btb slot is never filled
  localparam word_t REDIRECT_PC = 32'h0000_0FF0;

  logic          CLK;
  logic          nRST;
  ibus_rsp_t     ibus_rsp;
  ex_resolve_t   resolve;
  logic          ex_stall;
  ibus_req_t     ibus_req;
  fetch_ex_reg_t fetch_ex_reg;
  trap_t         trap;

  // memory model keeps its wait count per address
  logic  mem_busy;
  word_t last_addr;
  int    wait_left;

  // reference model with its own fetch pc and a shadow btb
  word_t                  exp_fpc;
  fetch_ex_reg_t          exp_reg;
  logic                   exp_trap_valid;
  word_t                  exp_trap_addr;
  logic [BTB_ENTRIES-1:0] sh_valid;
  logic [BTB_TAG_W-1:0]   sh_tag [BTB_ENTRIES];
  word_t                  sh_target [BTB_ENTRIES];
  logic [1:0]             sh_cnt [BTB_ENTRIES];
  logic [BTB_IDX_W-1:0]   fidx;
  logic [BTB_IDX_W-1:0]   ridx;
  logic                   pred_taken;
  logic                   rhit;

  int errors;
  int tests_run;
  int tests_failed;
  int test_mark;

  tspp_front_end tspp_front_end_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .ibus_rsp     (ibus_rsp),
    .resolve      (resolve),
    .ex_stall     (ex_stall),
    .ibus_req     (ibus_req),
    .fetch_ex_reg (fetch_ex_reg),
    .trap         (trap)
  );

  // the memory stores words so that the bus shows them with bytes reversed
  function automatic word_t bus_word(input word_t addr);
    word_t w;
    w = addr ^ INSTR_KEY;
    if (BUS_ENDIANNESS == "little") begin
      w = {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return w;
  endfunction

  assign ibus_rsp = {bus_word(ibus_req.addr), mem_busy};

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // a new address draws 0 to 2 busy cycles, a repeated one counts down
  always @(posedge CLK) begin
    #1;
    if (ibus_req.addr != last_addr) begin
      last_addr = ibus_req.addr;
      wait_left = $urandom % 3;
    end else if (wait_left != 0) begin
      wait_left--;
    end
    mem_busy = (wait_left != 0);
  end

  // shadow lookups for the model pc and for the resolving branch
  assign fidx       = exp_fpc[BTB_IDX_W+1:2];
  assign ridx       = resolve.pc[BTB_IDX_W+1:2];
  assign pred_taken = sh_valid[fidx] && (sh_tag[fidx] == exp_fpc[31:BTB_IDX_W+2]) &&
                      sh_cnt[fidx][1];
  assign rhit       = sh_valid[ridx] && (sh_tag[ridx] == resolve.pc[31:BTB_IDX_W+2]);

  // one step of the model per edge, redirects first, then stall, then busy
  always @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exp_fpc        <= RESET_PC;
      exp_reg        <= '0;
      exp_trap_valid <= 1'b0;
      sh_valid       <= '0;
    end else begin
      if (resolve.valid && resolve.mispredict) begin
        exp_fpc <= resolve.brj_addr;
        exp_reg <= '0;
      end else if (exp_fpc[1:0] != 2'b00) begin
        exp_fpc <= TRAP_VECTOR;
        exp_reg <= '0;
      end else if (!ex_stall && mem_busy) begin
        exp_reg <= '0;
      end else if (!ex_stall) begin
        exp_reg <= '{token: 1'b1, pc: exp_fpc, pc4: exp_fpc + 32'd4,
                     instr: exp_fpc ^ INSTR_KEY, prediction: pred_taken};
        exp_fpc <= pred_taken ? sh_target[fidx] : exp_fpc + 32'd4;
      end
      exp_trap_valid <= !(resolve.valid && resolve.mispredict) && (exp_fpc[1:0] != 2'b00);
      exp_trap_addr  <= exp_fpc;
      // a taken branch to a misaligned target leaves the table alone
      if (resolve.valid && resolve.taken && resolve.target[1:0] == 2'b00) begin
        sh_valid[ridx]  <= 1'b1;
        sh_tag[ridx]    <= resolve.pc[31:BTB_IDX_W+2];
        sh_target[ridx] <= resolve.target;
        sh_cnt[ridx]    <= !rhit ? 2'd2 : (sh_cnt[ridx] == 2'd3) ? 2'd3 : sh_cnt[ridx] + 2'd1;
      end else if (resolve.valid && !resolve.taken && rhit && sh_cnt[ridx] != 2'd0) begin
        sh_cnt[ridx] <= sh_cnt[ridx] - 2'd1;
      end
    end
  end

  a_reg_model: assert property (@(negedge CLK) disable iff (!nRST) fetch_ex_reg == exp_reg)
    else begin
      errors++;
      $display("[ERROR] %0t ns: fetch_ex_reg %h, model expects %h", $time, fetch_ex_reg, exp_reg);
    end

  a_instr_rule: assert property (@(negedge CLK) disable iff (!nRST) fetch_ex_reg.token |->
    (fetch_ex_reg.instr == (fetch_ex_reg.pc ^ INSTR_KEY) &&
     fetch_ex_reg.pc4 == fetch_ex_reg.pc + 32'd4))
    else begin
      errors++;
      $display("[ERROR] %0t ns: instr or pc4 wrong for pc %h", $time, fetch_ex_reg.pc);
    end

  // the bus follows the model pc and only goes idle while execute holds the pipe
  a_bus_model: assert property (@(negedge CLK) disable iff (!nRST)
    ibus_req.addr == exp_fpc &&
    ibus_req.ren == !(ex_stall && !(resolve.valid && resolve.mispredict) &&
                      exp_fpc[1:0] == 2'b00))
    else begin
      errors++;
      $display("[ERROR] %0t ns: bus request %h, expected address %h", $time, ibus_req, exp_fpc);
    end

  a_trap_model: assert property (@(negedge CLK) disable iff (!nRST)
    trap.valid == exp_trap_valid &&
    (!exp_trap_valid || (trap.epc == exp_trap_addr && trap.badaddr == exp_trap_addr)))
    else begin
      errors++;
      $display("[ERROR] %0t ns: trap %h, expected valid %b at %h", $time, trap,
               exp_trap_valid, exp_trap_addr);
    end

  // the slot in fetch during a redirect never reaches execute
  a_redirect_flush: assert property (@(negedge CLK) disable iff (!nRST)
    (resolve.valid && resolve.mispredict) |=> !fetch_ex_reg.token)
    else begin
      errors++;
      $display("[ERROR] %0t ns: token left behind a mispredict", $time);
    end

  a_stall_hold: assert property (@(negedge CLK) disable iff (!nRST)
    (ex_stall && !(resolve.valid && resolve.mispredict) && ibus_req.addr[1:0] == 2'b00)
    |=> ($stable(fetch_ex_reg) && $stable(ibus_req.addr)))
    else begin
      errors++;
      $display("[ERROR] %0t ns: register or fetch address moved under stall", $time);
    end

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic confirm(input logic cond, input string what);
    assert (cond) else begin
      errors++;
      $display("[ERROR] %0t ns: %s", $time, what);
    end
  endtask

  // execute reports one resolved branch for a single cycle
  task automatic drive_resolve(input word_t pc, input logic taken, input word_t target,
                               input logic mispredict, input word_t brj_addr);
    resolve = '{valid: 1'b1, pc: pc, taken: taken, target: target,
                mispredict: mispredict, brj_addr: brj_addr};
    next_cycle();
    resolve = '0;
  endtask

  task automatic await_token(input word_t pc, output fetch_ex_reg_t tok);
    int n;
    n = 0;
    next_cycle();
    while (!(fetch_ex_reg.token && fetch_ex_reg.pc == pc) && n < 60) begin
      next_cycle();
      n++;
    end
    tok = fetch_ex_reg;
    if (!(tok.token && tok.pc == pc)) begin
      errors++;
      $display("timeout: no instruction at pc %h reached execute within 60 cycles", pc);
    end
  endtask

  task automatic catch_trap();
    int n;
    n = 0;
    next_cycle();
    while (!trap.valid && n < 10) begin
      next_cycle();
      n++;
    end
    if (!trap.valid) begin
      errors++;
      $display("timeout: the misaligned redirect raised no trap within 10 cycles");
    end
  endtask

  task automatic close_test(input string name);
    // one more edge so that checks spanning two cycles land in this test
    next_cycle();
    tests_run++;
    if (errors == test_mark) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, errors - test_mark);
    end
    test_mark = errors;
  endtask

  initial begin
    fetch_ex_reg_t tok;
    void'($urandom(32'h195c_abce));
    nRST = 1'b0;
    ex_stall = 1'b0;
    resolve = '0;
    mem_busy = 1'b0;
    last_addr = '1;
    wait_left = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_mark = 0;
    repeat (16) @(posedge CLK);
    #1 nRST = 1'b1;

    confirm(!fetch_ex_reg.token && !trap.valid, "register or trap not clear after reset");
    confirm(ibus_req.addr == RESET_PC, "first fetch address is not the reset pc");
    close_test("reset");

    repeat (40) next_cycle();
    close_test("instruction data");

    drive_resolve(32'h300, 1'b1, 32'h400, 1'b1, 32'h400);
    await_token(32'h400, tok);
    close_test("mispredict");

    // install P = 0x520 -> 0x600, then replay the code leading up to P
    drive_resolve(32'h520, 1'b1, 32'h600, 1'b0, '0);
    drive_resolve(REDIRECT_PC, 1'b0, '0, 1'b1, 32'h510);
    await_token(32'h520, tok);
    confirm(tok.prediction, "branch not predicted taken after a taken resolve");
    await_token(32'h600, tok);
    drive_resolve(32'h520, 1'b0, '0, 1'b0, '0);
    drive_resolve(32'h520, 1'b0, '0, 1'b0, '0);
    drive_resolve(REDIRECT_PC, 1'b0, '0, 1'b1, 32'h510);
    await_token(32'h520, tok);
    confirm(!tok.prediction, "branch still predicted taken after two not-taken resolves");
    await_token(32'h524, tok);
    close_test("btb prediction");

    drive_resolve(32'h640, 1'b1, 32'h702, 1'b1, 32'h702);
    catch_trap();
    await_token(TRAP_VECTOR, tok);
    close_test("misaligned redirect");

    ex_stall = 1'b1;
    repeat (6) next_cycle();
    ex_stall = 1'b0;
    repeat (30) begin
      next_cycle();
      ex_stall = ($urandom % 4 == 0);
    end
    ex_stall = 1'b0;
    close_test("stall");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog in case the run stops making progress
  initial begin
    repeat (3000) @(posedge CLK);
    $display("run stopped, it did not end within 3000 cycles");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
rv32i_types_pkg.sv
tspp_fetch_stage.sv
branch_target_buffer.sv
tspp_hazard_unit.sv
tspp_front_end.sv
tb_tspp_front_end.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --timing --assert --top-module tb_tspp_front_end -f vlog.f -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
